/* hw/rv_pkg.sv */
package rv_pkg;

    ////////////////////////////////////////
    // widths and depths
    ////////////////////////////////////////
    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int IMEM_WORDS  = 64;
    localparam int IMEM_ADDR_W = $clog2(IMEM_WORDS);
    localparam int DMEM_WORDS  = 32;
    localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);

    // loader framing bytes, never stored
    localparam logic [7:0] LOAD_OPEN  = 8'hFE;
    localparam logic [7:0] LOAD_CLOSE = 8'hFF;

    // base opcodes of the supported subset
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    ////////////////////////////////////////
    // pipeline payloads
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_AND = 2'd2,
        ALU_OR  = 2'd3
    } alu_op_e;

    // all zero means bubble
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    alu_src_imm;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [XLEN-1:0]       rs1_val;
        logic [XLEN-1:0]       rs2_val;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
    } id_ex_t;

    typedef struct packed {
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        logic                  mem_to_reg;
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] rd;
    } ex_mem_t;

    // writeback bus, shared by regfile and forwarding
    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage

/* hw/program_store.sv */
`timescale 1ns/1ps

module program_store (
    input  logic                           clk_i,
    input  logic                           reset_n,
    input  logic                           write_enable_i,
    input  logic [7:0]                     instr_i,
    input  logic [rv_pkg::IMEM_ADDR_W-1:0] fetch_addr_i,
    output logic [rv_pkg::XLEN-1:0]        instr_o,
    output logic                           run_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOADING,
        ST_RUNNING
    } load_state_e;

    load_state_e                    state_q;
    logic [rv_pkg::IMEM_ADDR_W+1:0] byte_ptr_q;
    logic [rv_pkg::XLEN-1:0]        mem [rv_pkg::IMEM_WORDS];
    logic                           store_byte;

    // payload byte between the markers
    assign store_byte = write_enable_i && (state_q == ST_LOADING)
                        && (instr_i != rv_pkg::LOAD_CLOSE);

    always_ff @(posedge clk_i or negedge reset_n) begin
        if (!reset_n) begin
            state_q    <= ST_IDLE;
            byte_ptr_q <= '0;
        end else if (write_enable_i) begin
            case (state_q)
                ST_IDLE: begin
                    if (instr_i == rv_pkg::LOAD_OPEN) begin
                        state_q <= ST_LOADING;
                    end
                end
                ST_LOADING: begin
                    if (instr_i == rv_pkg::LOAD_CLOSE) begin
                        state_q <= ST_RUNNING;
                    end else begin
                        byte_ptr_q <= byte_ptr_q + 1'b1;
                    end
                end
                // running ignores everything until reset
                default: begin
                end
            endcase
        end
    end

    // little-endian packing, unwritten words stay zero
    always_ff @(posedge clk_i or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < rv_pkg::IMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (store_byte) begin
            mem[byte_ptr_q[rv_pkg::IMEM_ADDR_W+1:2]][{byte_ptr_q[1:0], 3'b000} +: 8] <= instr_i;
        end
    end

    assign instr_o = mem[fetch_addr_i];
    assign run_o   = (state_q == ST_RUNNING);

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                          clk_i,
    input  logic                          reset_n,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] dbg_addr_i,
    input  rv_pkg::wb_t                   wb_i,
    output logic [rv_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv_pkg::XLEN-1:0]       rs2_data_o,
    output logic [rv_pkg::XLEN-1:0]       dbg_data_o
);

    logic [rv_pkg::XLEN-1:0] regs [2**rv_pkg::REG_ADDR_W];
    logic                    wb_active;

    // x0 is never written
    assign wb_active = wb_i.we && (wb_i.rd != '0);

    always_ff @(posedge clk_i or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < 2**rv_pkg::REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_active) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign rs1_data_o = (wb_active && (wb_i.rd == rs1_i)) ? wb_i.data : regs[rs1_i];
    assign rs2_data_o = (wb_active && (wb_i.rd == rs2_i)) ? wb_i.data : regs[rs2_i];

    // inspection port shows committed state only
    assign dbg_data_o = regs[dbg_addr_i];

endmodule

/* hw/fetch_decode.sv */
`timescale 1ns/1ps

module fetch_decode (
    input  logic                           clk_i,
    input  logic                           reset_n,
    input  logic                           run_i,
    input  logic [rv_pkg::XLEN-1:0]        instr_i,
    input  logic [rv_pkg::XLEN-1:0]        rs1_data_i,
    input  logic [rv_pkg::XLEN-1:0]        rs2_data_i,
    output logic [rv_pkg::IMEM_ADDR_W-1:0] fetch_addr_o,
    output logic [rv_pkg::REG_ADDR_W-1:0]  rs1_o,
    output logic [rv_pkg::REG_ADDR_W-1:0]  rs2_o,
    output rv_pkg::id_ex_t                 id_ex_o
);

    logic [rv_pkg::XLEN-1:0]       pc_q;
    logic [rv_pkg::XLEN-1:0]       if_id_pc_q;
    logic [rv_pkg::XLEN-1:0]       if_id_instr_q;
    logic [6:0]                    opcode;
    logic [2:0]                    funct3;
    logic [6:0]                    funct7;
    logic [rv_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_pkg::XLEN-1:0]       imm_i;
    logic [rv_pkg::XLEN-1:0]       imm_s;
    logic [rv_pkg::XLEN-1:0]       imm_b;
    rv_pkg::ctrl_t                 ctrl;
    logic                          uses_rs2;
    logic                          load_use;
    logic                          branch_taken;
    rv_pkg::id_ex_t                id_ex_d;

    // byte PC, word-indexed memory
    assign fetch_addr_o = pc_q[rv_pkg::IMEM_ADDR_W+1:2];

    assign opcode = if_id_instr_q[6:0];
    assign rd     = if_id_instr_q[11:7];
    assign funct3 = if_id_instr_q[14:12];
    assign rs1_o  = if_id_instr_q[19:15];
    assign rs2_o  = if_id_instr_q[24:20];
    assign funct7 = if_id_instr_q[31:25];

    assign imm_i = {{20{if_id_instr_q[31]}}, if_id_instr_q[31:20]};
    assign imm_s = {{20{if_id_instr_q[31]}}, if_id_instr_q[31:25], if_id_instr_q[11:7]};
    assign imm_b = {{19{if_id_instr_q[31]}}, if_id_instr_q[31], if_id_instr_q[7],
                    if_id_instr_q[30:25], if_id_instr_q[11:8], 1'b0};

    ////////////////////////////////////////
    // control decode
    ////////////////////////////////////////
    always_comb begin
        ctrl     = '0;
        uses_rs2 = 1'b0;
        case (opcode)
            rv_pkg::OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                uses_rs2       = 1'b1;
                case (funct3)
                    3'b111:  ctrl.alu_op = rv_pkg::ALU_AND;
                    3'b110:  ctrl.alu_op = rv_pkg::ALU_OR;
                    default: ctrl.alu_op = funct7[5] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                endcase
            end
            rv_pkg::OP_ITYPE: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            rv_pkg::OP_LOAD: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            rv_pkg::OP_STORE: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                uses_rs2         = 1'b1;
            end
            // beq finishes here, nothing goes down the pipe
            rv_pkg::OP_BRANCH: uses_rs2 = 1'b1;
            default: begin
            end
        endcase
    end

    // load in EX whose result the decoding instruction needs
    assign load_use = id_ex_o.ctrl.mem_read && (id_ex_o.rd != '0)
                      && ((id_ex_o.rd == rs1_o) || (uses_rs2 && (id_ex_o.rd == rs2_o)));

    // not taken while stalled, operands may still be in flight
    assign branch_taken = (opcode == rv_pkg::OP_BRANCH) && (funct3 == 3'b000)
                          && (rs1_data_i == rs2_data_i) && !load_use;

    always_comb begin
        id_ex_d.ctrl    = ctrl;
        id_ex_d.rs1_val = rs1_data_i;
        id_ex_d.rs2_val = rs2_data_i;
        id_ex_d.imm     = (opcode == rv_pkg::OP_STORE) ? imm_s : imm_i;
        id_ex_d.rs1     = rs1_o;
        id_ex_d.rs2     = rs2_o;
        id_ex_d.rd      = rd;
    end

    ////////////////////////////////////////
    // PC, IF/ID and ID/EX
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge reset_n) begin
        if (!reset_n) begin
            pc_q          <= '0;
            if_id_pc_q    <= '0;
            if_id_instr_q <= '0;
            id_ex_o       <= '0;
        end else if (!run_i) begin
            pc_q          <= '0;
            if_id_pc_q    <= '0;
            if_id_instr_q <= '0;
            id_ex_o       <= '0;
        end else begin
            if (branch_taken) begin
                // redirect and squash the one fetched instruction
                pc_q          <= if_id_pc_q + imm_b;
                if_id_pc_q    <= '0;
                if_id_instr_q <= '0;
            end else if (!load_use) begin
                pc_q          <= pc_q + 32'd4;
                if_id_pc_q    <= pc_q;
                if_id_instr_q <= instr_i;
            end
            id_ex_o <= load_use ? '0 : id_ex_d;
        end
    end

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic            clk_i,
    input  logic            reset_n,
    input  rv_pkg::id_ex_t  id_ex_i,
    input  rv_pkg::wb_t     wb_i,
    output rv_pkg::ex_mem_t ex_mem_o
);

    logic [rv_pkg::XLEN-1:0] op_a;
    logic [rv_pkg::XLEN-1:0] rs2_fwd;
    logic [rv_pkg::XLEN-1:0] op_b;
    logic [rv_pkg::XLEN-1:0] alu_result;

    // newest producer wins, EX/MEM before MEM/WB
    function automatic logic [rv_pkg::XLEN-1:0] fwd_operand(
        input logic [rv_pkg::REG_ADDR_W-1:0] src,
        input logic [rv_pkg::XLEN-1:0]       reg_val,
        input rv_pkg::ex_mem_t               ex_mem,
        input rv_pkg::wb_t                   wb
    );
        logic [rv_pkg::XLEN-1:0] result;
        result = reg_val;
        // loads in EX/MEM are covered by the decode stall
        if (ex_mem.reg_write && !ex_mem.mem_read && (ex_mem.rd != '0)
            && (ex_mem.rd == src)) begin
            result = ex_mem.alu_result;
        end else if (wb.we && (wb.rd != '0) && (wb.rd == src)) begin
            result = wb.data;
        end
        return result;
    endfunction

    assign op_a    = fwd_operand(id_ex_i.rs1, id_ex_i.rs1_val, ex_mem_o, wb_i);
    assign rs2_fwd = fwd_operand(id_ex_i.rs2, id_ex_i.rs2_val, ex_mem_o, wb_i);
    assign op_b    = id_ex_i.ctrl.alu_src_imm ? id_ex_i.imm : rs2_fwd;

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////
    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            rv_pkg::ALU_SUB: alu_result = op_a - op_b;
            rv_pkg::ALU_AND: alu_result = op_a & op_b;
            rv_pkg::ALU_OR:  alu_result = op_a | op_b;
            default:         alu_result = op_a + op_b;
        endcase
    end

    // EX/MEM register
    always_ff @(posedge clk_i or negedge reset_n) begin
        if (!reset_n) begin
            ex_mem_o <= '0;
        end else begin
            ex_mem_o.reg_write  <= id_ex_i.ctrl.reg_write;
            ex_mem_o.mem_read   <= id_ex_i.ctrl.mem_read;
            ex_mem_o.mem_write  <= id_ex_i.ctrl.mem_write;
            ex_mem_o.mem_to_reg <= id_ex_i.ctrl.mem_to_reg;
            ex_mem_o.alu_result <= alu_result;
            // sw data must see forwarded rs2 too
            ex_mem_o.store_data <= rs2_fwd;
            ex_mem_o.rd         <= id_ex_i.rd;
        end
    end

endmodule

/* hw/memory_writeback.sv */
`timescale 1ns/1ps

module memory_writeback (
    input  logic                           clk_i,
    input  logic                           reset_n,
    input  rv_pkg::ex_mem_t                ex_mem_i,
    input  logic [rv_pkg::DMEM_ADDR_W-1:0] dbg_addr_i,
    output rv_pkg::wb_t                    wb_o,
    output logic [rv_pkg::XLEN-1:0]        dbg_data_o
);

    logic [rv_pkg::XLEN-1:0]        dmem [rv_pkg::DMEM_WORDS];
    logic [rv_pkg::DMEM_ADDR_W-1:0] word_idx;
    logic [rv_pkg::XLEN-1:0]        load_data;
    logic                           we_q;
    logic                           mem_to_reg_q;
    logic [rv_pkg::REG_ADDR_W-1:0]  rd_q;
    logic [rv_pkg::XLEN-1:0]        alu_q;
    logic [rv_pkg::XLEN-1:0]        load_q;

    // byte address, low two bits dropped
    assign word_idx  = ex_mem_i.alu_result[rv_pkg::DMEM_ADDR_W+1:2];
    assign load_data = dmem[word_idx];

    ////////////////////////////////////////
    // data memory
    ////////////////////////////////////////
    always_ff @(posedge clk_i or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < rv_pkg::DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem_i.mem_write) begin
            dmem[word_idx] <= ex_mem_i.store_data;
        end
    end

    // MEM/WB control
    always_ff @(posedge clk_i or negedge reset_n) begin
        if (!reset_n) begin
            we_q         <= 1'b0;
            mem_to_reg_q <= 1'b0;
            rd_q         <= '0;
        end else begin
            we_q         <= ex_mem_i.reg_write;
            mem_to_reg_q <= ex_mem_i.mem_to_reg;
            rd_q         <= ex_mem_i.rd;
        end
    end

    // MEM/WB data
    always_ff @(posedge clk_i) begin
        alu_q  <= ex_mem_i.alu_result;
        load_q <= load_data;
    end

    always_comb begin
        wb_o.we   = we_q;
        wb_o.rd   = rd_q;
        wb_o.data = mem_to_reg_q ? load_q : alu_q;
    end

    assign dbg_data_o = dmem[dbg_addr_i];

endmodule

/* hw/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
    input  logic       clk_i,
    input  logic       reset_n,
    input  logic       write_enable_i,
    input  logic [7:0] instr_i,
    input  logic [4:0] address_i,
    input  logic       sel_reg_i,
    input  logic [1:0] byte_sel_i,
    output logic [7:0] value_o
);

    logic                           run;
    logic [rv_pkg::IMEM_ADDR_W-1:0] fetch_addr;
    logic [rv_pkg::XLEN-1:0]        instr;
    logic [rv_pkg::REG_ADDR_W-1:0]  rs1;
    logic [rv_pkg::REG_ADDR_W-1:0]  rs2;
    logic [rv_pkg::XLEN-1:0]        rs1_data;
    logic [rv_pkg::XLEN-1:0]        rs2_data;
    rv_pkg::id_ex_t                 id_ex;
    rv_pkg::ex_mem_t                ex_mem;
    rv_pkg::wb_t                    wb;
    logic [rv_pkg::XLEN-1:0]        reg_dbg;
    logic [rv_pkg::XLEN-1:0]        mem_dbg;
    logic [rv_pkg::XLEN-1:0]        dbg_word;

    program_store i_program_store (
        .clk_i          (clk_i),
        .reset_n        (reset_n),
        .write_enable_i (write_enable_i),
        .instr_i        (instr_i),
        .fetch_addr_i   (fetch_addr),
        .instr_o        (instr),
        .run_o          (run)
    );

    fetch_decode i_fetch_decode (
        .clk_i        (clk_i),
        .reset_n      (reset_n),
        .run_i        (run),
        .instr_i      (instr),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .fetch_addr_o (fetch_addr),
        .rs1_o        (rs1),
        .rs2_o        (rs2),
        .id_ex_o      (id_ex)
    );

    reg_file i_reg_file (
        .clk_i      (clk_i),
        .reset_n    (reset_n),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .dbg_addr_i (address_i),
        .wb_i       (wb),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .dbg_data_o (reg_dbg)
    );

    execute_stage i_execute_stage (
        .clk_i    (clk_i),
        .reset_n  (reset_n),
        .id_ex_i  (id_ex),
        .wb_i     (wb),
        .ex_mem_o (ex_mem)
    );

    memory_writeback i_memory_writeback (
        .clk_i      (clk_i),
        .reset_n    (reset_n),
        .ex_mem_i   (ex_mem),
        .dbg_addr_i (address_i),
        .wb_o       (wb),
        .dbg_data_o (mem_dbg)
    );

    ////////////////////////////////////////
    // inspection byte select
    ////////////////////////////////////////
    assign dbg_word = sel_reg_i ? reg_dbg : mem_dbg;
    assign value_o  = dbg_word[{byte_sel_i, 3'b000} +: 8];

endmodule

/* verif/tb_programs.svh */
////////////////////////////////////////
// RV32I instruction encodings
////////////////////////////////////////
function automatic logic [31:0] alu_word(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
endfunction

function automatic logic [31:0] load_word(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
endfunction

function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

// beq, offset relative to the branch itself
function automatic logic [31:0] branch_word(input logic [4:0] rs1, input logic [4:0] rs2,
                                            input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
endfunction

////////////////////////////////////////
// loader stimulus
////////////////////////////////////////
task automatic apply_reset();
    @(posedge clk_i);
    reset_n <= 1'b0;
    repeat (3) @(posedge clk_i);
    reset_n <= 1'b1;
endtask

// random idle gap with unstrobed noise, then one strobed byte
task automatic send_byte(input logic [7:0] b);
    int gap;
    gap = {$random(seed)} % 3;
    repeat (gap) begin
        @(posedge clk_i);
        write_enable_i <= 1'b0;
        instr_i        <= 8'($random(seed));
    end
    @(posedge clk_i);
    write_enable_i <= 1'b1;
    instr_i        <= b;
endtask

// strobed junk before the open marker and after the close marker
task automatic load_program();
    apply_reset();
    // self-loop beq parks the core so the PC never wraps back into the program
    prog.push_back(branch_word(5'd0, 5'd0, 13'd0));
    send_byte(8'h13);
    send_byte(8'hFE);
    foreach (prog[i]) begin
        for (int b = 0; b < 4; b++) begin
            send_byte(prog[i][8*b +: 8]);
        end
    end
    send_byte(8'hFF);
    send_byte(8'hFE);
    send_byte(8'h93);
    @(posedge clk_i);
    write_enable_i <= 1'b0;
endtask

/* verif/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

    localparam int POLL_LIMIT = 100;

    logic        clk_i = 1'b0;
    logic        reset_n;
    logic        write_enable_i;
    logic [7:0]  instr_i;
    logic [4:0]  address_i;
    logic        sel_reg_i;
    logic [1:0]  byte_sel_i;
    logic [7:0]  value_o;

    int          seed = 20;
    int          test_errors = 0;
    int          passed = 0;
    int          failed = 0;
    logic [31:0] prog [$];
    logic [31:0] x [8];

    `include "tb_programs.svh"

    rv_core i_dut (.*);

    always #10 clk_i = ~clk_i;

    // poll one byte until it shows the expected value
    task automatic check_byte(input string name, input logic sel, input logic [4:0] addr,
                              input logic [1:0] bsel, input logic [7:0] exp);
        int cycles;
        cycles = 0;
        @(posedge clk_i);
        sel_reg_i  <= sel;
        address_i  <= addr;
        byte_sel_i <= bsel;
        @(negedge clk_i);
        while ((value_o !== exp) && (cycles < POLL_LIMIT)) begin
            @(negedge clk_i);
            cycles++;
        end
        if ((cycles == POLL_LIMIT) && (value_o !== exp)) begin
            $display("%s: %s word %0d byte %0d did not settle within %0d cycles",
                     name, sel ? "register" : "memory", addr, bsel, POLL_LIMIT);
        end
        assert (value_o === exp) else begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, value_o);
            test_errors++;
        end
    endtask

    task automatic check_word(input string name, input logic sel, input logic [4:0] addr,
                              input logic [31:0] exp);
        for (int b = 0; b < 4; b++) begin
            check_byte(name, sel, addr, 2'(b), exp[8*b +: 8]);
        end
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            passed++;
            $display("test %s passed", name);
        end else begin
            failed++;
            $display("test %s failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        reset_n        = 1'b0;
        write_enable_i = 1'b0;
        instr_i        = 8'h00;
        address_i      = '0;
        sel_reg_i      = 1'b0;
        byte_sel_i     = '0;
        apply_reset();

        for (int a = 0; a < 32; a++) begin
            check_word("reset_state", 1'b1, 5'(a), 32'h0);
            check_word("reset_state", 1'b0, 5'(a), 32'h0);
        end
        end_test("reset_state");

        ////////////////////////////////////////
        // dependent ALU chain
        ////////////////////////////////////////
        x[1] = 32'h123;
        x[2] = 32'h456;
        x[3] = x[1] + x[2];
        x[4] = x[1] - x[3];
        x[5] = x[4] & x[3];
        x[6] = x[5] | x[2];
        prog = '{addi_word(5'd1, 5'd0, 12'h123), addi_word(5'd2, 5'd0, 12'h456),
                 alu_word(7'h00, 3'b000, 5'd3, 5'd1, 5'd2),
                 alu_word(7'h20, 3'b000, 5'd4, 5'd1, 5'd3),
                 alu_word(7'h00, 3'b111, 5'd5, 5'd4, 5'd3),
                 alu_word(7'h00, 3'b110, 5'd6, 5'd5, 5'd2)};
        load_program();
        // last writer first, so earlier results are final too
        for (int r = 6; r > 0; r--) begin
            check_word("alu_forwarding", 1'b1, 5'(r), x[r]);
        end
        end_test("alu_forwarding");

        // sw, lw and an add that needs the loaded value at once
        x[1] = 32'h3A5;
        x[2] = 32'h10;
        x[3] = x[1];
        x[4] = x[3] + x[1];
        prog = '{addi_word(5'd1, 5'd0, 12'h3A5), addi_word(5'd2, 5'd0, 12'h010),
                 store_word(5'd1, 5'd2, 12'd8), load_word(5'd3, 5'd2, 12'd8),
                 alu_word(7'h00, 3'b000, 5'd4, 5'd3, 5'd1)};
        load_program();
        check_word("load_use", 1'b1, 5'd4, x[4]);
        check_word("load_use", 1'b1, 5'd3, x[3]);
        check_word("load_use", 1'b0, 5'((x[2] + 32'd8) >> 2), x[1]);
        end_test("load_use");

        ////////////////////////////////////////
        // taken beq skips x4, not-taken beq lets x5 run
        ////////////////////////////////////////
        prog = '{addi_word(5'd1, 5'd0, 12'd5), addi_word(5'd2, 5'd0, 12'd5),
                 addi_word(5'd3, 5'd0, 12'd7), addi_word(5'd6, 5'd0, 12'd1),
                 branch_word(5'd1, 5'd2, 13'd8), addi_word(5'd4, 5'd0, 12'd9),
                 branch_word(5'd1, 5'd3, 13'd8), addi_word(5'd5, 5'd0, 12'h011)};
        load_program();
        check_word("branches", 1'b1, 5'd5, 32'h11);
        check_word("branches", 1'b1, 5'd4, 32'h0);
        check_word("branches", 1'b1, 5'd6, 32'h1);
        end_test("branches");

        // a shifted or extended image would break x8
        prog = '{addi_word(5'd7, 5'd0, 12'h02C), addi_word(5'd8, 5'd7, 12'h031)};
        load_program();
        check_word("loader_filter", 1'b1, 5'd8, 32'h2C + 32'h31);
        check_word("loader_filter", 1'b1, 5'd7, 32'h2C);
        end_test("loader_filter");

        $display("tests passed: %0d, tests failed: %0d", passed, failed);
        if (failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+verif
hw/rv_pkg.sv
hw/program_store.sv
hw/reg_file.sv
hw/fetch_decode.sv
hw/execute_stage.sv
hw/memory_writeback.sv
hw/rv_core.sv
verif/tb_rv_core.sv
